// File: src/noisePkg.sv
`default_nettype none

package noisePkg;

	// channel register map, byte-wide writes
	localparam logic [1:0] AddrEnv    = 2'd0; // loop, const volume, volume/period
	localparam logic [1:0] AddrPeriod = 2'd2; // mode bit and period index
	localparam logic [1:0] AddrLength = 2'd3; // length index, envelope restart

	// width of the random shift register
	localparam int LfsrWidth = 15;

	// timer cycles between two shift steps, by period index
	localparam int unsigned periodTable [16] = '{
		4, 8, 16, 32,
		64, 96, 128, 160,
		202, 254, 380, 508,
		762, 1016, 2034, 4068
	};

	// half-frame counts loaded by a length write
	localparam logic [7:0] lengthTable [32] = '{
		8'd10,  8'd254, // 0x00
		8'd20,  8'd2,
		8'd40,  8'd4,
		8'd80,  8'd6,
		8'd160, 8'd8,
		8'd60,  8'd10,
		8'd14,  8'd12,
		8'd26,  8'd14,
		8'd12,  8'd16, // 0x10
		8'd24,  8'd18,
		8'd48,  8'd20,
		8'd96,  8'd22,
		8'd192, 8'd24,
		8'd72,  8'd26,
		8'd16,  8'd28,
		8'd32,  8'd30
	};

endpackage

`default_nettype wire

// File: src/noiseRegs.sv
`default_nettype none

module noiseRegs import noisePkg::*; #(
	parameter int TimerWidth = 12
) (
	input  logic       ACLK,
	input  logic       rst,
	input  logic       req,
	input  logic [1:0] addr,
	input  logic [7:0] wrData,
	output logic       ack,
	output logic       loopFlag,
	output logic       constVol,
	output logic       shortMode,
	output logic [3:0] volPeriod,
	output logic [3:0] periodIdx,
	output logic [4:0] lengthIdx,
	output logic       lengthLoad,
	output logic       envRestart
);

	logic wrStrobe;

	// a new transfer is taken once per req, never while ack is still up
	assign wrStrobe = req && !ack;

	// every period index must give a reload value that fits the timer
	function automatic int unsigned maxReload();
		int unsigned m;
		m = 0;
		for (int i = 0; i < 16; i++) begin
			if (periodTable[i] > m) m = periodTable[i];
		end
		return m;
	endfunction

	if (maxReload() >= (64'd1 << TimerWidth)) begin : gTimerFit
		$error("TimerWidth %0d too narrow for period table", TimerWidth);
	end

	always_ff @(posedge ACLK) begin
		if (rst) begin
			ack        <= 1'b0;
			loopFlag   <= 1'b0;
			constVol   <= 1'b0;
			volPeriod  <= 4'd0;
			shortMode  <= 1'b0;
			periodIdx  <= 4'd0;
			lengthIdx  <= 5'd0;
			lengthLoad <= 1'b0;
			envRestart <= 1'b0;
		end else begin
			lengthLoad <= 1'b0; // single-cycle pulses
			envRestart <= 1'b0;
			if (wrStrobe) begin
				ack <= 1'b1;
				case (addr)
					AddrEnv: begin
						loopFlag  <= wrData[5];
						constVol  <= wrData[4];
						volPeriod <= wrData[3:0];
					end
					AddrPeriod: begin
						shortMode <= wrData[7];
						periodIdx <= wrData[3:0];
					end
					AddrLength: begin
						lengthIdx  <= wrData[7:3];
						lengthLoad <= 1'b1;
						envRestart <= 1'b1; // also restarts the envelope
					end
					default: ; // address 1 acked, nothing stored
				endcase
			end else if (!req) begin
				ack <= 1'b0;
			end
		end
	end

	aRiseNeedsReq: assert property (@(posedge ACLK) disable iff (rst)
		$rose(ack) |-> $past(req))
		else $error("ack raised without a pending req");

	aFallAfterReq: assert property (@(posedge ACLK) disable iff (rst)
		$fell(ack) |-> !$past(req))
		else $error("ack dropped while req still high");

endmodule

`default_nettype wire

// File: src/periodTimer.sv
`default_nettype none

module periodTimer import noisePkg::*; #(
	parameter int TimerWidth = 12
) (
	input  logic       ACLK,
	input  logic       rst,
	input  logic [3:0] periodIdx,
	output logic       step
);

	logic [TimerWidth-1:0] count;
	logic [TimerWidth-1:0] reload;
	logic                  atEnd;

	// table lookup, sampled only at reload time
	assign reload = TimerWidth'(periodTable[periodIdx]);

	// count of 0 only happens straight out of reset
	assign atEnd = (count == TimerWidth'(1)) || (count == '0);

	always_ff @(posedge ACLK) begin
		if (rst) begin
			count <= '0;
			step  <= 1'b0;
		end else if (atEnd) begin
			count <= reload;
			step  <= 1'b1;
		end else begin
			count <= count - TimerWidth'(1);
			step  <= 1'b0;
		end
	end

	// shortest reload is several cycles, so steps never touch
	aStepIsolated: assert property (@(posedge ACLK) disable iff (rst)
		step |=> !step)
		else $error("step held high for more than one cycle");

endmodule

`default_nettype wire

// File: src/noiseLfsr.sv
`default_nettype none

module noiseLfsr import noisePkg::*; (
	input  logic ACLK,
	input  logic rst,
	input  logic step,
	input  logic shortMode,
	output logic rndBit
);

	logic [LfsrWidth-1:0] lfsr;
	logic                 tap;
	logic                 feedback;

	// short mode gives the 93-step metallic sequence
	assign tap      = shortMode ? lfsr[6] : lfsr[1];
	assign feedback = lfsr[0] ^ tap;

	always_ff @(posedge ACLK) begin
		if (rst) begin
			lfsr <= LfsrWidth'(1);
		end else if (step) begin
			lfsr <= {feedback, lfsr[LfsrWidth-1:1]}; // shift right
		end
	end

	assign rndBit = lfsr[0]; // 1 mutes the channel

	// the all-zero state would lock up, seeding and feedback must avoid it
	aNotStuck: assert property (@(posedge ACLK) disable iff (rst)
		lfsr != '0)
		else $error("noise shift register reached all zero");

endmodule

`default_nettype wire

// File: src/envelopeUnit.sv
`default_nettype none

module envelopeUnit (
	input  logic       ACLK,
	input  logic       rst,
	input  logic       quarterFrame,
	input  logic       envRestart,
	input  logic       loopFlag,
	input  logic       constVol,
	input  logic [3:0] volPeriod,
	output logic [3:0] volume
);

	logic       startFlag;
	logic [3:0] divider;
	logic [3:0] decay;

	always_ff @(posedge ACLK) begin
		if (rst) begin
			startFlag <= 1'b0;
			divider   <= 4'd0;
			decay     <= 4'd0;
		end else begin
			if (envRestart) begin
				startFlag <= 1'b1; // picked up at the next quarter frame
			end else if (quarterFrame && startFlag) begin
				startFlag <= 1'b0;
			end

			if (quarterFrame) begin
				if (startFlag) begin
					decay   <= 4'd15;
					divider <= volPeriod;
				end else if (divider == 4'd0) begin
					divider <= volPeriod;
					if (decay != 4'd0) begin
						decay <= decay - 4'd1;
					end else if (loopFlag) begin
						decay <= 4'd15; // looping envelope
					end
				end else begin
					divider <= divider - 4'd1;
				end
			end
		end
	end

	// volPeriod doubles as the fixed volume
	assign volume = constVol ? volPeriod : decay;

endmodule

`default_nettype wire

// File: src/lengthCounter.sv
`default_nettype none

module lengthCounter import noisePkg::*; (
	input  logic       ACLK,
	input  logic       rst,
	input  logic       halfFrame,
	input  logic       lengthLoad,
	input  logic       loopFlag,
	input  logic [4:0] lengthIdx,
	output logic       active
);

	logic [7:0] count;
	logic       countDown;

	// loopFlag is the halt bit here
	assign countDown = halfFrame && !loopFlag && (count != 8'd0);

	always_ff @(posedge ACLK) begin
		if (rst) begin
			count <= 8'd0;
		end else if (lengthLoad) begin
			count <= lengthTable[lengthIdx]; // load wins over a tick
		end else if (countDown) begin
			count <= count - 8'd1;
		end
	end

	assign active = (count != 8'd0);

endmodule

`default_nettype wire

// File: src/noiseChannel.sv
`default_nettype none

module noiseChannel #(
	parameter int TimerWidth = 12
) (
	input  logic       ACLK,
	input  logic       rst,
	input  logic       req,
	input  logic [1:0] addr,
	input  logic [7:0] wrData,
	input  logic       quarterFrame,
	input  logic       halfFrame,
	output logic       ack,
	output logic [3:0] sample
);

	logic       loopFlag;
	logic       constVol;
	logic       shortMode;
	logic [3:0] volPeriod;
	logic [3:0] periodIdx;
	logic [4:0] lengthIdx;
	logic       lengthLoad;
	logic       envRestart;
	logic       step;
	logic       rndBit;
	logic [3:0] volume;
	logic       active;

	noiseRegs #(
		.TimerWidth(TimerWidth)
	) i_noiseRegs (
		.ACLK      (ACLK),
		.rst       (rst),
		.req       (req),
		.addr      (addr),
		.wrData    (wrData),
		.ack       (ack),
		.loopFlag  (loopFlag),
		.constVol  (constVol),
		.shortMode (shortMode),
		.volPeriod (volPeriod),
		.periodIdx (periodIdx),
		.lengthIdx (lengthIdx),
		.lengthLoad(lengthLoad),
		.envRestart(envRestart)
	);

	periodTimer #(
		.TimerWidth(TimerWidth)
	) i_periodTimer (
		.ACLK     (ACLK),
		.rst      (rst),
		.periodIdx(periodIdx),
		.step     (step)
	);

	noiseLfsr i_noiseLfsr (
		.ACLK     (ACLK),
		.rst      (rst),
		.step     (step),
		.shortMode(shortMode),
		.rndBit   (rndBit)
	);

	envelopeUnit i_envelopeUnit (
		.ACLK        (ACLK),
		.rst         (rst),
		.quarterFrame(quarterFrame),
		.envRestart  (envRestart),
		.loopFlag    (loopFlag),
		.constVol    (constVol),
		.volPeriod   (volPeriod),
		.volume      (volume)
	);

	lengthCounter i_lengthCounter (
		.ACLK      (ACLK),
		.rst       (rst),
		.halfFrame (halfFrame),
		.lengthLoad(lengthLoad),
		.loopFlag  (loopFlag),
		.lengthIdx (lengthIdx),
		.active    (active)
	);

	// silent when the length ran out or the noise bit is set
	assign sample = (active && !rndBit) ? volume : 4'd0;

endmodule

`default_nettype wire

// File: verification/tbNoiseChannel.sv
`default_nettype none

module tbNoiseChannel import noisePkg::*; ();

	localparam int ResetLen   = 16;
	localparam int WriteLen   = 16 * 8; // writes, each bounded by its ack waits
	localparam int LongLen    = 400;
	localparam int ShortLen   = 40 * 96; // slowest random period index is 5
	localparam int EnvLen     = 2 * 80 * 4;
	localparam int LenLen     = 2 * 14 * 4;
	localparam int CycleLimit = ResetLen + WriteLen + LongLen + ShortLen + EnvLen + LenLen + 300;

	logic       ACLK;
	logic       rst;
	logic       req;
	logic [1:0] addr;
	logic [7:0] wrData;
	logic       quarterFrame;
	logic       halfFrame;
	logic       ack;
	logic [3:0] sample;

	int          errCount;
	int          cycles;
	int unsigned rngState;
	string       testName;

	// reference state
	logic                 mAck;
	logic                 mLoop;
	logic                 mConst;
	logic                 mShort;
	logic [3:0]           mVol;
	logic [3:0]           mPidx;
	logic [4:0]           mLenIdx;
	logic                 mLenLoad;
	logic                 mEnvRestart;
	int                   mTimer;
	logic                 mStep;
	logic [LfsrWidth-1:0] mLfsr;
	logic                 mStart;
	logic [3:0]           mDiv;
	logic [3:0]           mDecay;
	int                   mLen;
	logic [3:0]           expSample;

	noiseChannel i_noiseChannel (
		.ACLK        (ACLK),
		.rst         (rst),
		.req         (req),
		.addr        (addr),
		.wrData      (wrData),
		.quarterFrame(quarterFrame),
		.halfFrame   (halfFrame),
		.ack         (ack),
		.sample      (sample)
	);

	always #50 ACLK = ~ACLK;

	function automatic int unsigned lcgNext(input int unsigned s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always @(posedge ACLK) begin
		if (rst) begin
			mAck <= 1'b0;
			mLoop <= 1'b0;
			mConst <= 1'b0;
			mShort <= 1'b0;
			mVol <= 4'd0;
			mPidx <= 4'd0;
			mLenIdx <= 5'd0;
			mLenLoad <= 1'b0;
			mEnvRestart <= 1'b0;
			mTimer <= 0;
			mStep <= 1'b0;
			mLfsr <= LfsrWidth'(1);
			mStart <= 1'b0;
			mDiv <= 4'd0;
			mDecay <= 4'd0;
			mLen <= 0;
		end else begin
			mLenLoad <= 1'b0;
			mEnvRestart <= 1'b0;
			if (req && !mAck) begin
				mAck <= 1'b1;
				if (addr == AddrEnv) begin
					mLoop <= wrData[5];
					mConst <= wrData[4];
					mVol <= wrData[3:0];
				end else if (addr == AddrPeriod) begin
					mShort <= wrData[7];
					mPidx <= wrData[3:0];
				end else if (addr == AddrLength) begin
					mLenIdx <= wrData[7:3];
					mLenLoad <= 1'b1;
					mEnvRestart <= 1'b1;
				end
			end else if (!req) begin
				mAck <= 1'b0;
			end
			if (mTimer <= 1) begin // reload edge gives the step
				mTimer <= periodTable[mPidx];
				mStep <= 1'b1;
			end else begin
				mTimer <= mTimer - 1;
				mStep <= 1'b0;
			end
			if (mStep) begin
				mLfsr <= {mLfsr[0] ^ (mShort ? mLfsr[6] : mLfsr[1]), mLfsr[LfsrWidth-1:1]};
			end
			if (mEnvRestart) begin
				mStart <= 1'b1;
			end else if (quarterFrame) begin
				mStart <= 1'b0;
			end
			if (quarterFrame && mStart) begin
				mDecay <= 4'd15;
				mDiv <= mVol;
			end else if (quarterFrame && mDiv == 4'd0) begin
				mDiv <= mVol;
				if (mDecay > 0) mDecay <= mDecay - 4'd1;
				else if (mLoop) mDecay <= 4'd15;
			end else if (quarterFrame) begin
				mDiv <= mDiv - 4'd1;
			end
			if (mLenLoad) begin
				mLen <= lengthTable[mLenIdx];
			end else if (halfFrame && !mLoop && mLen > 0) begin
				mLen <= mLen - 1; // halt holds the count
			end
		end
	end

	assign expSample = (mLen != 0 && !mLfsr[0]) ? (mConst ? mVol : mDecay) : 4'd0;

	aSampleMatch: assert property (@(posedge ACLK) disable iff (rst) sample == expSample)
		else begin
			errCount++;
			$display("MISMATCH %s sample expected %0d actual %0d", testName,
				$sampled(expSample), $sampled(sample));
		end

	aAckMatch: assert property (@(posedge ACLK) disable iff (rst) ack == mAck)
		else begin
			errCount++;
			$display("MISMATCH %s ack expected %0d actual %0d", testName,
				$sampled(mAck), $sampled(ack));
		end

	aAckPrompt: assert property (@(posedge ACLK) disable iff (rst) $rose(req) |=> ack)
		else begin
			errCount++;
			$display("%s: ack was not high one edge after req rose", testName);
		end

	aResetQuiet: assert property (@(posedge ACLK) $fell(rst) |-> (sample == 4'd0 && !ack))
		else begin
			errCount++;
			$display("reset did not leave sample at zero and ack low");
		end

	always @(posedge ACLK) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("timeout: run passed %0d cycles without finishing", CycleLimit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic writeReg(input logic [1:0] a, input logic [7:0] d);
		int waitCycles;
		@(posedge ACLK);
		#10;
		req = 1'b1;
		addr = a;
		wrData = d;
		waitCycles = 0;
		while (!ack && waitCycles < 8) begin
			@(posedge ACLK);
			#10;
			waitCycles++;
		end
		if (!ack) begin
			errCount++;
			$display("%s: write to address %0d was never acknowledged", testName, a);
		end
		req = 1'b0;
		waitCycles = 0;
		while (ack && waitCycles < 8) begin
			@(posedge ACLK);
			#10;
			waitCycles++;
		end
		if (ack) begin
			errCount++;
			$display("%s: ack stayed high after req dropped", testName);
		end
	endtask

	task automatic frameTicks(input bit half, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge ACLK);
			#10;
			if (half) halfFrame = 1'b1;
			else quarterFrame = 1'b1;
			@(posedge ACLK);
			#10;
			halfFrame = 1'b0;
			quarterFrame = 1'b0;
			repeat (2) @(posedge ACLK);
		end
	endtask

	initial begin
		int unsigned idx;
		int unsigned vol;
		ACLK = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		addr = 2'd0;
		wrData = 8'd0;
		quarterFrame = 1'b0;
		halfFrame = 1'b0;
		errCount = 0;
		cycles = 0;
		rngState = 66;
		testName = "reset";
		repeat (ResetLen) @(posedge ACLK);
		#10;
		rst = 1'b0;
		repeat (4) @(posedge ACLK);

		testName = "longMode";
		writeReg(AddrEnv, 8'h1F); // constant volume 15
		writeReg(AddrPeriod, 8'h00);
		writeReg(AddrLength, 8'h08); // index 1, long count
		writeReg(2'd1, 8'hFF); // unmapped address
		repeat (LongLen) @(posedge ACLK);

		testName = "shortMode";
		rngState = lcgNext(rngState);
		idx = rngState[23:16] % 6;
		rngState = lcgNext(rngState);
		vol = rngState[23:16] % 16;
		writeReg(AddrEnv, 8'h10 | 8'(vol));
		writeReg(AddrPeriod, 8'h80 | 8'(idx));
		repeat (40 * periodTable[idx]) @(posedge ACLK);

		testName = "envelope";
		rngState = lcgNext(rngState);
		vol = rngState[23:16] % 4; // divider period
		writeReg(AddrEnv, 8'(vol));
		writeReg(AddrLength, 8'h08);
		frameTicks(1'b0, 80);
		testName = "envelopeLoop";
		writeReg(AddrEnv, 8'h20 | 8'(vol));
		writeReg(AddrLength, 8'h08);
		frameTicks(1'b0, 80);

		testName = "length";
		writeReg(AddrEnv, 8'h1A);
		writeReg(AddrLength, 8'h00); // index 0 counts 10
		frameTicks(1'b1, 14);
		testName = "lengthHalt";
		writeReg(AddrEnv, 8'h3A);
		writeReg(AddrLength, 8'h00);
		frameTicks(1'b1, 14);

		repeat (4) @(posedge ACLK);
		$display("errors: %0d", errCount);
		if (errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/noisePkg.sv
src/noiseRegs.sv
src/periodTimer.sv
src/noiseLfsr.sv
src/envelopeUnit.sv
src/lengthCounter.sv
src/noiseChannel.sv
verification/tbNoiseChannel.sv

// File: Bender.yml
package:
  name: noise_channel

sources:
  - src/noisePkg.sv
  - src/noiseRegs.sv
  - src/periodTimer.sv
  - src/noiseLfsr.sv
  - src/envelopeUnit.sv
  - src/lengthCounter.sv
  - src/noiseChannel.sv
  - target: test
    files:
      - verification/tbNoiseChannel.sv
